/* rtl/snakeGeomPkg.sv */
package snakeGeomPkg;

	typedef logic [4:0] colT;
	typedef logic [4:0] rowT;
	typedef logic [9:0] pixT;
	typedef logic [2:0] rgbT;
	typedef logic [4:0] segCountT; // 0 to 20

	// Playfield grid
	localparam int cellSize    = 25;
	localparam int fieldOrigin = 2; // First pixel of cell 0
	localparam int gridCols    = 24;
	localparam int gridRows    = 19;
	localparam int maxSegments = 20;

	// Border walls, inclusive pixel ranges
	localparam pixT leftWallEnd     = 10'd2;
	localparam pixT rightWallStart  = 10'd602;
	localparam pixT rightWallEnd    = 10'd604;
	localparam pixT topWallEnd      = 10'd2;
	localparam pixT bottomWallStart = 10'd477;
	localparam pixT bottomWallEnd   = 10'd479;

	localparam rgbT wallRgb  = 3'b111;
	localparam rgbT snakeRgb = 3'b010;
	localparam rgbT fruitRgb = 3'b100;
	localparam rgbT overRgb  = 3'b001;
	localparam rgbT blankRgb = 3'b000;

	// Cells used on every new game
	localparam colT startCol      = 5'd3;
	localparam rowT startRow      = 5'd3;
	localparam colT fruitStartCol = 5'd9;
	localparam rowT fruitStartRow = 5'd2;

endpackage

/* rtl/snakeCtrlPkg.sv */
package snakeCtrlPkg;

	typedef enum logic [1:0] {
		dirUp,
		dirDown,
		dirLeft,
		dirRight
	} dirT;

	// Easy levels wrap at the border, hard levels die there
	typedef enum logic [1:0] {
		diffEasy,
		diffNormal,
		diffHard,
		diffInsane
	} diffT;

	typedef enum logic [1:0] {
		gsIdle,
		gsPlay,
		gsOver
	} gameStateT;

	// Step period per difficulty in timer units
	localparam int unsigned stepUnits [4] = '{28, 18, 10, 6};

	typedef logic [3:0] bcdT;
	typedef bcdT [3:0] scoreT; // Digit 0 is the units

endpackage

/* rtl/snakeStateIf.sv */
`timescale 1ns/1ps

interface snakeStateIf;
	import snakeGeomPkg::*;

	colT      headCol;
	rowT      headRow;
	colT      fruitCol;
	rowT      fruitRow;
	colT      bodyCol [maxSegments]; // Segment 0 sits next to the head
	rowT      bodyRow [maxSegments];
	segCountT snakeLength;
	logic     gameOver;

	modport engine (
		output headCol, headRow, fruitCol, fruitRow,
		output bodyCol, bodyRow, snakeLength, gameOver
	);

	modport render (
		input headCol, headRow, fruitCol, fruitRow,
		input bodyCol, bodyRow, snakeLength, gameOver
	);

endinterface

/* rtl/stepTimer.sv */
`timescale 1ns/1ps

module stepTimer #(
	parameter int unsigned cyclesPerUnit = 250000
) (
	input  logic              clk,
	input  logic              rst,
	input  logic              running,
	input  snakeCtrlPkg::diffT difficulty,
	output logic              step
);
	import snakeCtrlPkg::*;

	logic [31:0] count;
	logic [31:0] period;

	assign period = stepUnits[difficulty] * cyclesPerUnit;

	always_ff @(posedge clk) begin
		if (rst) begin
			count <= '0;
			step <= 1'b0;
		end else if (!running) begin
			count <= '0; // Hold at zero between games
			step <= 1'b0;
		end else if (count >= period - 1) begin
			// Also catches a shorter period after a difficulty change
			count <= '0;
			step <= 1'b1;
		end else begin
			count <= count + 1;
			step <= 1'b0;
		end
	end

	stepIsPulse: assert property (
		@(posedge clk) disable iff (rst)
		step |=> !step
	) else $error("step held high for two cycles");

endmodule

/* rtl/snakeEngine.sv */
`timescale 1ns/1ps

module snakeEngine (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  logic               paused,
	input  snakeCtrlPkg::dirT  direction,
	input  snakeCtrlPkg::diffT difficulty,
	input  snakeGeomPkg::colT  nextFruitCol,
	input  snakeGeomPkg::rowT  nextFruitRow,
	input  logic               step,
	output logic               running,
	output logic               eat,
	output logic               scoreClear,
	snakeStateIf.engine        st
);
	import snakeGeomPkg::*;
	import snakeCtrlPkg::*;

	gameStateT state;
	colT       headCol, fruitCol, nextCol;
	rowT       headRow, fruitRow, nextRow;
	colT       bodyCol [maxSegments];
	rowT       bodyRow [maxSegments];
	segCountT  snakeLength;
	logic      hitBorder, hitSelf, hardEdge, onFruit;

	assign hardEdge = (difficulty == diffHard) || (difficulty == diffInsane);

	// Candidate head, wrapped at the border
	always_comb begin
		nextCol = headCol;
		nextRow = headRow;
		hitBorder = 1'b0;
		case (direction)
			dirUp: begin
				hitBorder = (headRow == '0);
				nextRow = hitBorder ? rowT'(gridRows - 1) : headRow - 1'b1;
			end
			dirDown: begin
				hitBorder = (headRow == rowT'(gridRows - 1));
				nextRow = hitBorder ? '0 : headRow + 1'b1;
			end
			dirLeft: begin
				hitBorder = (headCol == '0);
				nextCol = hitBorder ? colT'(gridCols - 1) : headCol - 1'b1;
			end
			default: begin
				hitBorder = (headCol == colT'(gridCols - 1));
				nextCol = hitBorder ? '0 : headCol + 1'b1;
			end
		endcase
	end

	// Checked against the body before the shift
	always_comb begin
		hitSelf = 1'b0;
		for (int i = 0; i < maxSegments; i++)
			if (i < snakeLength && bodyCol[i] == nextCol && bodyRow[i] == nextRow)
				hitSelf = 1'b1;
	end

	assign onFruit = (nextCol == fruitCol) && (nextRow == fruitRow);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= gsIdle;
			headCol <= startCol;
			headRow <= startRow;
			fruitCol <= fruitStartCol;
			fruitRow <= fruitStartRow;
			snakeLength <= '0;
			eat <= 1'b0;
			scoreClear <= 1'b0;
		end else begin
			eat <= 1'b0;
			scoreClear <= 1'b0;
			case (state)
				gsIdle, gsOver: if (start) begin
					state <= gsPlay;
					headCol <= startCol;
					headRow <= startRow;
					fruitCol <= fruitStartCol;
					fruitRow <= fruitStartRow;
					snakeLength <= '0;
					scoreClear <= 1'b1;
				end
				gsPlay: if (step && !paused) begin
					if ((hitBorder && hardEdge) || hitSelf) begin
						state <= gsOver; // Head keeps its cell
					end else begin
						headCol <= nextCol;
						headRow <= nextRow;
						bodyCol[0] <= headCol;
						bodyRow[0] <= headRow;
						for (int i = 1; i < maxSegments; i++) begin
							bodyCol[i] <= bodyCol[i-1];
							bodyRow[i] <= bodyRow[i-1];
						end
						if (onFruit) begin
							if (snakeLength != segCountT'(maxSegments))
								snakeLength <= snakeLength + 1'b1;
							fruitCol <= nextFruitCol;
							fruitRow <= nextFruitRow;
							eat <= 1'b1;
						end
					end
				end
				default: state <= gsIdle;
			endcase
		end
	end

	assign running = (state == gsPlay);

	assign st.headCol = headCol;
	assign st.headRow = headRow;
	assign st.fruitCol = fruitCol;
	assign st.fruitRow = fruitRow;
	assign st.bodyCol = bodyCol;
	assign st.bodyRow = bodyRow;
	assign st.snakeLength = snakeLength;
	assign st.gameOver = (state == gsOver);

	headInGrid: assert property (
		@(posedge clk) disable iff (rst)
		headCol < gridCols && headRow < gridRows
	) else $error("head left the grid");

	lengthCap: assert property (
		@(posedge clk) disable iff (rst)
		snakeLength <= maxSegments
	) else $error("snake longer than body capacity");

	// The fruit register holds the sampled cell when eat shows
	fruitInGrid: assert property (
		@(posedge clk) disable iff (rst)
		eat |-> fruitCol < gridCols && fruitRow < gridRows
	) else $error("new fruit cell outside the grid");

endmodule

/* rtl/scoreCounter.sv */
`timescale 1ns/1ps

module scoreCounter (
	input  logic                clk,
	input  logic                rst,
	input  logic                eat,
	input  logic                scoreClear,
	output snakeCtrlPkg::scoreT score
);
	import snakeCtrlPkg::*;

	scoreT nextScore;
	logic  carry;

	// Ripple increment, 9999 rolls over to 0000
	always_comb begin
		carry = 1'b1;
		for (int d = 0; d < 4; d++) begin
			if (!carry)
				nextScore[d] = score[d];
			else if (score[d] == 4'd9)
				nextScore[d] = 4'd0;
			else begin
				nextScore[d] = score[d] + 4'd1;
				carry = 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst || scoreClear)
			score <= '0;
		else if (eat)
			score <= nextScore;
	end

	digitsBcd: assert property (
		@(posedge clk) disable iff (rst)
		score[0] <= 4'd9 && score[1] <= 4'd9 && score[2] <= 4'd9 && score[3] <= 4'd9
	) else $error("score digit outside BCD range");

endmodule

/* rtl/pixelRenderer.sv */
`timescale 1ns/1ps

module pixelRenderer (
	input  logic              clk,
	input  logic              rst,
	input  logic              videoOn,
	input  snakeGeomPkg::pixT pixX,
	input  snakeGeomPkg::pixT pixY,
	snakeStateIf.render       st,
	output snakeGeomPkg::rgbT rgb
);
	import snakeGeomPkg::*;

	pixT  relX, relY;
	colT  cellCol;
	rowT  cellRow;
	logic inField, onWall, onSnake, onFruit;

	assign relX = pixX - pixT'(fieldOrigin);
	assign relY = pixY - pixT'(fieldOrigin);
	assign cellCol = colT'(relX / cellSize);
	assign cellRow = rowT'(relY / cellSize);

	// relX wraps below the origin, hence the extra compare
	assign inField = (pixX >= fieldOrigin) && (relX < cellSize * gridCols)
		&& (pixY >= fieldOrigin) && (relY < cellSize * gridRows);

	assign onWall = (pixX <= leftWallEnd)
		|| (pixX >= rightWallStart && pixX <= rightWallEnd)
		|| (pixY <= topWallEnd)
		|| (pixY >= bottomWallStart && pixY <= bottomWallEnd);

	always_comb begin
		onSnake = (cellCol == st.headCol) && (cellRow == st.headRow);
		for (int i = 0; i < maxSegments; i++)
			if (i < st.snakeLength && st.bodyCol[i] == cellCol && st.bodyRow[i] == cellRow)
				onSnake = 1'b1;
		onSnake = onSnake && inField;
	end

	assign onFruit = inField && (cellCol == st.fruitCol) && (cellRow == st.fruitRow);

	always_ff @(posedge clk) begin
		if (rst)
			rgb <= blankRgb;
		else if (!videoOn)
			rgb <= blankRgb; // Blanking interval
		else if (onWall)
			rgb <= wallRgb;
		else if (st.gameOver)
			rgb <= overRgb;
		else if (onSnake)
			rgb <= snakeRgb;
		else if (onFruit)
			rgb <= fruitRgb;
		else
			rgb <= blankRgb;
	end

endmodule

/* rtl/snakeTop.sv */
`timescale 1ns/1ps

module snakeTop #(
	parameter int unsigned cyclesPerUnit = 250000 // Clock cycles per timer unit
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    start,
	input  logic                    paused,
	input  snakeCtrlPkg::dirT       direction,
	input  snakeCtrlPkg::diffT      difficulty,
	input  snakeGeomPkg::colT       fruitCol,
	input  snakeGeomPkg::rowT       fruitRow,
	input  logic                    videoOn,
	input  snakeGeomPkg::pixT       pixX,
	input  snakeGeomPkg::pixT       pixY,
	output snakeGeomPkg::rgbT       rgb,
	output snakeCtrlPkg::scoreT     score,
	output snakeGeomPkg::colT       headCol,
	output snakeGeomPkg::rowT       headRow,
	output snakeGeomPkg::segCountT  snakeLength,
	output logic                    gameOver
);
	logic step;
	logic running;
	logic eat;
	logic scoreClear;

	snakeStateIf stIf ();

	stepTimer #(.cyclesPerUnit(cyclesPerUnit)) timer (
		.clk(clk),
		.rst(rst),
		.running(running),
		.difficulty(difficulty),
		.step(step)
	);

	snakeEngine engine (
		.clk(clk),
		.rst(rst),
		.start(start),
		.paused(paused),
		.direction(direction),
		.difficulty(difficulty),
		.nextFruitCol(fruitCol),
		.nextFruitRow(fruitRow),
		.step(step),
		.running(running),
		.eat(eat),
		.scoreClear(scoreClear),
		.st(stIf.engine)
	);

	scoreCounter scorer (
		.clk(clk),
		.rst(rst),
		.eat(eat),
		.scoreClear(scoreClear),
		.score(score)
	);

	pixelRenderer renderer (
		.clk(clk),
		.rst(rst),
		.videoOn(videoOn),
		.pixX(pixX),
		.pixY(pixY),
		.st(stIf.render),
		.rgb(rgb)
	);

	assign headCol = stIf.headCol;
	assign headRow = stIf.headRow;
	assign snakeLength = stIf.snakeLength;
	assign gameOver = stIf.gameOver;

endmodule

/* test/snakeTbAsserts.svh */
resetClean: assert property (
	@(posedge clk) $fell(rst) |-> !gameOver && score == '0 && snakeLength == '0
) else stopWithFail($sformatf(
	"mismatch gameOver,score,snakeLength got %h,%h,%h expected 0,0000,00",
	$sampled(gameOver), $sampled(score), $sampled(snakeLength)));

startHome: assert property (
	@(posedge clk) disable iff (rst)
	start |=> headCol == startCol && headRow == startRow && !gameOver
) else stopWithFail($sformatf("mismatch head,gameOver got %h,%h,%h expected %h,%h,0",
	$sampled(headCol), $sampled(headRow), $sampled(gameOver), startCol, startRow));

startClearsScore: assert property (
	@(posedge clk) disable iff (rst)
	start |=> ##1 score == '0
) else stopWithFail($sformatf("mismatch score got %h expected 0000", $sampled(score)));

moveCol: assert property (
	@(posedge clk) disable iff (rst)
	headMoved |-> headCol == stepCol(prevCol, prevDir)
) else stopWithFail($sformatf("mismatch headCol got %h expected %h",
	$sampled(headCol), stepCol($sampled(prevCol), $sampled(prevDir))));

moveRow: assert property (
	@(posedge clk) disable iff (rst)
	headMoved |-> headRow == stepRow(prevRow, prevDir)
) else stopWithFail($sformatf("mismatch headRow got %h expected %h",
	$sampled(headRow), stepRow($sampled(prevRow), $sampled(prevDir))));

moveLegal: assert property (
	@(posedge clk) disable iff (rst)
	headMoved |-> !deathOnMove
) else stopWithFail("head moved where the game should have ended");

deathCause: assert property (
	@(posedge clk) disable iff (rst)
	$rose(gameOver) |-> deathInPlace
) else stopWithFail("game ended without a border or body hit");

deathHold: assert property (
	@(posedge clk) disable iff (rst)
	$rose(gameOver) |-> headCol == prevCol && headRow == prevRow
) else stopWithFail($sformatf("mismatch head got %h,%h expected %h,%h",
	$sampled(headCol), $sampled(headRow), $sampled(prevCol), $sampled(prevRow)));

pauseHold: assert property (
	@(posedge clk) disable iff (rst)
	paused && prevPaused && !prevGo |-> headCol == prevCol && headRow == prevRow
) else stopWithFail($sformatf("mismatch head while paused got %h,%h expected %h,%h",
	$sampled(headCol), $sampled(headRow), $sampled(prevCol), $sampled(prevRow)));

growLen: assert property (
	@(posedge clk) disable iff (rst)
	headMoved |-> snakeLength == ((landed && mLen < maxSegments) ? mLen + 1 : mLen)
) else stopWithFail($sformatf("mismatch snakeLength got %h model %h",
	$sampled(snakeLength), $sampled(mLen)));

scoreStep: assert property (
	@(posedge clk) disable iff (rst)
	headMoved && landed |=> score == bcdPlusOne(prevScore)
) else stopWithFail($sformatf("mismatch score got %h expected %h",
	$sampled(score), bcdPlusOne($sampled(prevScore))));

renderRgb: assert property (
	@(posedge clk) disable iff (rst)
	prevChk |-> rgb == rgbExpected
) else stopWithFail($sformatf("mismatch rgb got %h expected %h",
	$sampled(rgb), $sampled(rgbExpected)));

/* test/snakeTb.sv */
`timescale 1ns/1ps

module snakeTb;
	import snakeGeomPkg::*;
	import snakeCtrlPkg::*;

	logic     clk = 1'b0;
	logic     rst, start, paused, videoOn;
	dirT      direction;
	diffT     difficulty;
	colT      fruitCol;
	rowT      fruitRow;
	pixT      pixX, pixY;
	rgbT      rgb;
	scoreT    score;
	colT      headCol;
	rowT      headRow;
	segCountT snakeLength;
	logic     gameOver;
	integer   seed = 32'hda79a71c;

	// Reference model, prev* hold the values seen at the last edge
	colT      prevCol, mFruitCol, prevFruitCol;
	rowT      prevRow, mFruitRow, prevFruitRow;
	colT      mBodyCol [maxSegments];
	rowT      mBodyRow [maxSegments];
	segCountT mLen;
	scoreT    prevScore;
	dirT      prevDir;
	diffT     prevDiff;
	logic     prevGo, prevPaused, renderChk, prevChk, prevVid;
	pixT      prevX, prevY;
	int       eats;
	logic     headMoved, landed;
	logic     deathOnMove, deathInPlace;
	rgbT      rgbExpected;

	snakeTop #(.cyclesPerUnit(1)) dut (.*);

	always #4 clk = ~clk;

	assign headMoved = (headCol != prevCol || headRow != prevRow) && !prevGo;
	assign landed = (headCol == mFruitCol) && (headRow == mFruitRow);

	function automatic colT stepCol(colT c, dirT d);
		if (d == dirRight)
			return colT'((c + 1) % gridCols);
		if (d == dirLeft)
			return colT'((c + gridCols - 1) % gridCols);
		return c;
	endfunction

	function automatic rowT stepRow(rowT r, dirT d);
		if (d == dirDown)
			return rowT'((r + 1) % gridRows);
		if (d == dirUp)
			return rowT'((r + gridRows - 1) % gridRows);
		return r;
	endfunction

	function automatic logic deathExpected(colT c, rowT r, dirT d, diffT f);
		logic atEdge, hit;
		atEdge = (d == dirUp && r == 0) || (d == dirDown && r == gridRows - 1)
			|| (d == dirLeft && c == 0) || (d == dirRight && c == gridCols - 1);
		hit = atEdge && (f == diffHard || f == diffInsane);
		for (int i = 0; i < mLen; i++)
			if (mBodyCol[i] == stepCol(c, d) && mBodyRow[i] == stepRow(r, d))
				hit = 1'b1;
		return hit;
	endfunction

	// Decimal add, then split back into digits
	function automatic scoreT bcdPlusOne(scoreT s);
		int    v;
		scoreT r;
		v = (s[3] * 1000 + s[2] * 100 + s[1] * 10 + s[0] + 1) % 10000;
		for (int d = 0; d < 4; d++) begin
			r[d] = bcdT'(v % 10);
			v = v / 10;
		end
		return r;
	endfunction

	function automatic rgbT expRgb(pixT x, pixT y, logic vid);
		int   c, r;
		logic snake;
		c = (int'(x) - fieldOrigin) / cellSize;
		r = (int'(y) - fieldOrigin) / cellSize;
		if (!vid)
			return blankRgb;
		if (x <= leftWallEnd || (x >= rightWallStart && x <= rightWallEnd)
			|| y <= topWallEnd || (y >= bottomWallStart && y <= bottomWallEnd))
			return wallRgb;
		if (prevGo)
			return overRgb;
		if (x < fieldOrigin || y < fieldOrigin || c >= gridCols || r >= gridRows)
			return blankRgb;
		snake = (c == prevCol) && (r == prevRow);
		for (int i = 0; i < mLen; i++)
			if (mBodyCol[i] == c && mBodyRow[i] == r)
				snake = 1'b1;
		if (snake)
			return snakeRgb;
		if (c == mFruitCol && r == mFruitRow)
			return fruitRgb;
		return blankRgb;
	endfunction

	// Model predictions from the state held before the edge
	always_comb begin
		deathOnMove = deathExpected(prevCol, prevRow, prevDir, prevDiff);
		deathInPlace = deathExpected(headCol, headRow, prevDir, prevDiff);
		rgbExpected = expRgb(prevX, prevY, prevVid);
	end

	always @(posedge clk) begin
		prevCol <= headCol;
		prevRow <= headRow;
		prevScore <= score;
		prevDir <= direction;
		prevDiff <= difficulty;
		prevGo <= gameOver;
		prevPaused <= paused;
		prevFruitCol <= fruitCol;
		prevFruitRow <= fruitRow;
		prevX <= pixX;
		prevY <= pixY;
		prevVid <= videoOn;
		prevChk <= renderChk;
		if (rst || start) begin
			mLen <= '0;
			mFruitCol <= fruitStartCol;
			mFruitRow <= fruitStartRow;
		end else if (headMoved) begin
			mBodyCol[0] <= prevCol;
			mBodyRow[0] <= prevRow;
			for (int i = 1; i < maxSegments; i++) begin
				mBodyCol[i] <= mBodyCol[i-1];
				mBodyRow[i] <= mBodyRow[i-1];
			end
			if (landed) begin
				if (mLen < maxSegments)
					mLen <= mLen + 1'b1;
				mFruitCol <= prevFruitCol; // Cell on the input at the step
				mFruitRow <= prevFruitRow;
				eats <= eats + 1;
			end
		end
	end

	task automatic stopWithFail(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic waitMove();
		colT c;
		rowT r;
		int  n;
		c = headCol;
		r = headRow;
		n = 0;
		while (headCol == c && headRow == r) begin
			@(negedge clk);
			n++;
			if (n > 200)
				stopWithFail("timeout waiting for the head to move");
		end
		@(negedge clk); // Let the model catch up
		fruitCol = colT'($unsigned($random(seed)) % gridCols);
		fruitRow = rowT'($unsigned($random(seed)) % gridRows);
	endtask

	task automatic waitOver();
		int n;
		n = 0;
		while (!gameOver) begin
			@(negedge clk);
			n++;
			if (n > 1000)
				stopWithFail("timeout waiting for game over");
		end
		@(negedge clk);
	endtask

	// Right and down only, so the head never meets its own body
	task automatic chaseFruit(input int target);
		int moves;
		moves = 0;
		while (eats < target) begin
			direction = (headCol != mFruitCol) ? dirRight : dirDown;
			waitMove();
			moves++;
			if (moves > 800)
				stopWithFail("snake did not reach the fruit");
		end
	endtask

	task automatic applyPixel(input int x, input int y, input logic vid);
		pixX = pixT'(x);
		pixY = pixT'(y);
		videoOn = vid;
		renderChk = 1'b1;
		@(negedge clk);
	endtask

	task automatic pulseStart();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	`include "snakeTbAsserts.svh"

	initial begin
		rst = 1'b1;
		start = 1'b0;
		paused = 1'b0;
		direction = dirRight;
		difficulty = diffEasy;
		fruitCol = fruitStartCol;
		fruitRow = fruitStartRow;
		videoOn = 1'b0;
		pixX = '0;
		pixY = '0;
		renderChk = 1'b0;
		eats = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		pulseStart();
		repeat (25) waitMove(); // Full lap of row 3 with a wrap
		paused = 1'b1;
		repeat (120) @(negedge clk);
		paused = 1'b0;
		chaseFruit(11);

		paused = 1'b1; // Freeze the field for rendering
		repeat (2) @(negedge clk);
		applyPixel(0, 100, 1'b1);
		applyPixel(fieldOrigin + cellSize * headCol + 12, fieldOrigin + cellSize * headRow + 12,
			1'b1);
		applyPixel(fieldOrigin + cellSize * mFruitCol + 12, fieldOrigin + cellSize * mFruitRow + 12,
			1'b1);
		applyPixel(300, 240, 1'b0);
		renderChk = 1'b0;
		paused = 1'b0;

		direction = dirRight;
		waitMove();
		difficulty = diffHard;
		direction = dirUp;
		waitOver();

		difficulty = diffEasy;
		pulseStart();
		chaseFruit(eats + 4);
		direction = dirRight;
		waitMove();
		direction = dirDown;
		waitMove();
		direction = dirLeft;
		waitMove();
		direction = dirUp; // Back into segment 2
		waitOver();
		applyPixel(300, 240, 1'b1);
		renderChk = 1'b0;
		repeat (2) @(negedge clk);

		$display("TEST PASSED");
		$finish;
	end

endmodule

/* compile.f */
+incdir+test
rtl/snakeGeomPkg.sv
rtl/snakeCtrlPkg.sv
rtl/snakeStateIf.sv
rtl/stepTimer.sv
rtl/snakeEngine.sv
rtl/scoreCounter.sv
rtl/pixelRenderer.sv
rtl/snakeTop.sv
test/snakeTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= snakeTb
BUILD     ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
